// ==== verification/core_tests.txt ====
# P byte_address word loads the program, E address data is an expected store
# H ends the file, all numbers in hex
P 04 8c010000
P 08 8c020004
P 0c 24211111
P 10 ac010480
P 14 24422222
P 18 ac020484
P 1c 24033333
P 20 ac030488
# addu subu and or, then slt with a negative operand
P 24 00222021
P 28 ac04048c
P 2c 00612823
P 30 ac050490
P 34 00623024
P 38 ac060494
P 3c 00223825
P 40 ac070498
P 44 2408fffe
P 48 0101482a
P 4c ac09049c
P 50 0028502a
P 54 ac0a04a0
P 58 ac0804a4
# sw then lw back through a base register
P 5c 240c0200
P 60 ad820004
P 64 8d8d0004
P 68 ac0d04a8
# beq not taken, then taken over the store at 0x78
P 6c 10220001
P 70 ac0104ac
P 74 10830001
P 78 ac0204b0
P 7c ac0304b0
# write to r0 is lost, jr r0 halts
P 80 24005555
P 84 ac0004b4
P 88 00000008
E 480 00001111
E 484 00002222
E 488 00003333
E 48c 00003333
E 490 00002222
E 494 00002222
E 498 00003333
E 49c 00000001
E 4a0 00000000
E 4a4 fffffffe
E 204 00002222
E 4a8 00002222
E 4ac 00001111
E 4b0 00003333
E 4b4 00000000
H

// ==== sources.f ====
hw/mips_isa_pkg.sv
hw/mem_map_pkg.sv
hw/instr_ram.sv
hw/data_ram.sv
hw/register_file.sv
hw/alu.sv
hw/program_counter.sv
hw/cpu_control.sv
hw/mips_core_top.sv
verification/mips_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the core with its testbench, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module mips_core_tb -o mips_core_sim \
    && ./obj_dir/mips_core_sim | tee /dev/stderr | grep -qx "sim passed" \
    && echo "simulation run passed" \
    || { echo "simulation run failed"; exit 1; }

// ==== verification/mips_core_tb.sv ====
`timescale 1ns/1ps

module mips_core_tb;

    localparam int store_timeout = 100;
    localparam int halt_timeout  = 100;
    localparam int quiet_cycles  = 20;

    logic        clk;
    logic        arst_n;
    logic        start;
    logic        prog_we;
    logic [31:0] prog_address;
    logic [31:0] prog_data;
    logic        store_valid;
    logic [31:0] store_address;
    logic [31:0] store_data;
    logic        halted;

    // expected store stream in program order
    logic [31:0] exp_address_q [$];
    logic [31:0] exp_data_q [$];
    int          stores_seen;
    int          total;

    mips_core_top UUT (
        .clk(clk),
        .arst_n(arst_n),
        .start(start),
        .prog_we(prog_we),
        .prog_address(prog_address),
        .prog_data(prog_data),
        .store_valid(store_valid),
        .store_address(store_address),
        .store_data(store_data),
        .halted(halted)
    );

    always #20 clk = ~clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_on(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "run aborted");
    endtask

    // one word through the program load port
    task automatic load_word(input logic [31:0] address, input logic [31:0] word);
        @(negedge clk);
        prog_we      = 1'b1;
        prog_address = address;
        prog_data    = word;
        @(negedge clk);
        prog_we      = 1'b0;
    endtask

    task automatic read_tests();
        int             fd;
        int             n;
        logic [7:0]     tag;
        logic [31:0]    a;
        logic [31:0]    d;
        logic [1023:0]  line;
        bit             done;
        fd = $fopen("verification/core_tests.txt", "r");
        if (fd == 0) begin
            stop_on("could not open verification/core_tests.txt");
        end
        done = 1'b0;
        while (!done) begin
            tag = 8'h0;
            n = $fscanf(fd, "%s", tag);
            if (n != 1) begin
                stop_on("test file ended before its H line");
            end
            if (tag == "#") begin
                // rest of a comment line
                n = $fgets(line, fd);
            end else if (tag == "P" || tag == "E") begin
                n = $fscanf(fd, "%h %h", a, d);
                if (n != 2) begin
                    stop_on("test file has a line with missing address or data");
                end
                if (tag == "P") begin
                    load_word(a, d);
                end else begin
                    exp_address_q.push_back(a);
                    exp_data_q.push_back(d);
                end
            end else if (tag == "H") begin
                done = 1'b1;
            end else begin
                stop_on("test file has a line of unknown kind");
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_store(input int index);
        int cycles;
        cycles = 0;
        while (stores_seen <= index) begin
            if (cycles == store_timeout) begin
                $display("store number %0d never arrived", index);
                stop_on("timed out waiting for a store");
            end
            @(posedge clk);
            cycles++;
        end
    endtask

    task automatic wait_halt();
        int cycles;
        cycles = 0;
        while (!halted) begin
            if (cycles == halt_timeout) begin
                stop_on("timed out waiting for the core to halt");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // store port monitor on the falling edge where outputs have settled
    always @(negedge clk) begin
        if (store_valid) begin
            if (exp_address_q.size() == 0) begin
                $display("store to %h with data %h at %0t", store_address, store_data, $time);
                stop_on("store seen with none expected");
            end else begin
                check_value(store_address, exp_address_q[0], "store address");
                check_value(store_data, exp_data_q[0], "store data");
                void'(exp_address_q.pop_front());
                void'(exp_data_q.pop_front());
                stores_seen++;
            end
        end else if (halted && exp_address_q.size() != 0) begin
            $display("%0d stores still pending at %0t", exp_address_q.size(), $time);
            stop_on("core halted before all expected stores were seen");
        end
    end

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        start        = 1'b0;
        prog_we      = 1'b0;
        prog_address = 32'h0;
        prog_data    = 32'h0;
        stores_seen  = 0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_value(32'(halted), 32'h0, "halted after reset");
        check_value(32'(store_valid), 32'h0, "store_valid after reset");
        read_tests();
        total = exp_address_q.size();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        for (int k = 0; k < total; k++) begin
            wait_store(k);
        end
        wait_halt();
        // the monitor flags any store after the halt
        repeat (quiet_cycles) begin
            @(negedge clk);
            check_value(32'(halted), 32'h1, "halted level");
        end
        $display("sim passed");
        $finish;
    end

endmodule

// ==== hw/mips_core_top.sv ====
`timescale 1ns/1ps

module mips_core_top (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        start,
    input  logic        prog_we,
    input  logic [31:0] prog_address,
    input  logic [31:0] prog_data,
    output logic        store_valid,
    output logic [31:0] store_address,
    output logic [31:0] store_data,
    output logic        halted
);

    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    mips_isa_pkg::instr_word_u ir;

    mips_isa_pkg::alu_op_t alu_op;
    logic        alu_use_imm;
    logic        rf_we;
    logic        wb_from_mem;
    logic        rd_from_r;
    logic        pc_advance;
    logic        pc_branch;
    logic        pc_jump;
    logic        dram_we;
    logic        ir_load;
    logic        at_halt;

    logic [31:0] rs_value;
    logic [31:0] rt_value;
    logic [31:0] imm_ext;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        alu_zero;
    logic [31:0] dram_readdata;
    logic [31:0] wb_data;
    logic [4:0]  wb_index;

    // instruction register, loaded in fetch
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ir <= '0;
        end else if (ir_load) begin
            ir <= instr_readdata;
        end
    end

    assign imm_ext  = {{16{ir.i.imm[15]}}, ir.i.imm};
    assign alu_b    = alu_use_imm ? imm_ext : rt_value;
    assign wb_data  = wb_from_mem ? dram_readdata : alu_result;
    assign wb_index = rd_from_r ? ir.r.rd : ir.i.rt;

    // every sw shows up on the store port
    assign store_valid   = dram_we;
    assign store_address = alu_result;
    assign store_data    = rt_value;

    program_counter u_pc (
        .clk(clk), .arst_n(arst_n),
        .advance(pc_advance), .branch(pc_branch), .jump(pc_jump),
        .branch_offset(ir.i.imm), .jump_target(rs_value),
        .pc(instr_address), .at_halt(at_halt)
    );

    instr_ram u_iram (
        .instr_address(instr_address), .instr_readdata(instr_readdata),
        .clk(clk), .prog_we(prog_we),
        .prog_address(prog_address), .prog_data(prog_data)
    );

    register_file u_rf (
        .clk(clk), .arst_n(arst_n),
        .rs_index(ir.i.rs), .rt_index(ir.i.rt), .rd_index(wb_index),
        .write_data(wb_data), .we(rf_we),
        .rs_value(rs_value), .rt_value(rt_value)
    );

    alu u_alu (
        .a(rs_value), .b(alu_b), .op(alu_op),
        .result(alu_result), .zero(alu_zero)
    );

    data_ram u_dram (
        .clk(clk), .address(alu_result), .writedata(rt_value),
        .we(dram_we), .readdata(dram_readdata)
    );

    cpu_control u_ctrl (
        .clk(clk), .arst_n(arst_n), .start(start), .instr(ir),
        .alu_zero(alu_zero), .at_halt(at_halt),
        .alu_op(alu_op), .alu_use_imm(alu_use_imm), .rf_we(rf_we),
        .wb_from_mem(wb_from_mem), .rd_from_r(rd_from_r),
        .pc_advance(pc_advance), .pc_branch(pc_branch), .pc_jump(pc_jump),
        .dram_we(dram_we), .ir_load(ir_load), .halted(halted)
    );

endmodule

// ==== hw/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      start,
    input  mips_isa_pkg::instr_word_u instr,
    input  logic                      alu_zero,
    input  logic                      at_halt,
    output mips_isa_pkg::alu_op_t     alu_op,
    output logic                      alu_use_imm,
    output logic                      rf_we,
    output logic                      wb_from_mem,
    output logic                      rd_from_r,
    output logic                      pc_advance,
    output logic                      pc_branch,
    output logic                      pc_jump,
    output logic                      dram_we,
    output logic                      ir_load,
    output logic                      halted
);

    enum logic [2:0] {
        st_idle,
        st_fetch,
        st_execute,
        st_memory,
        st_writeback,
        st_halt
    } state, state_next;

    logic is_lw;
    logic is_sw;

    assign is_lw     = (instr.i.opcode == mips_isa_pkg::op_lw);
    assign is_sw     = (instr.i.opcode == mips_isa_pkg::op_sw);
    assign rd_from_r = (instr.r.opcode == mips_isa_pkg::op_special);
    assign halted    = (state == st_halt);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // strobes per state
    always_comb begin
        alu_op      = mips_isa_pkg::alu_add;
        alu_use_imm = 1'b0;
        rf_we       = 1'b0;
        wb_from_mem = 1'b0;
        pc_advance  = 1'b0;
        pc_branch   = 1'b0;
        pc_jump     = 1'b0;
        dram_we     = 1'b0;
        ir_load     = 1'b0;
        case (state)
            st_fetch: begin
                ir_load = 1'b1;
            end
            st_execute: begin
                case (instr.i.opcode)
                    mips_isa_pkg::op_special: begin
                        rf_we      = 1'b1;
                        pc_advance = 1'b1;
                        case (instr.r.funct)
                            mips_isa_pkg::fn_addu: alu_op = mips_isa_pkg::alu_add;
                            mips_isa_pkg::fn_subu: alu_op = mips_isa_pkg::alu_sub;
                            mips_isa_pkg::fn_and:  alu_op = mips_isa_pkg::alu_and;
                            mips_isa_pkg::fn_or:   alu_op = mips_isa_pkg::alu_or;
                            mips_isa_pkg::fn_slt:  alu_op = mips_isa_pkg::alu_slt;
                            mips_isa_pkg::fn_jr: begin
                                rf_we      = 1'b0;
                                pc_advance = 1'b0;
                                pc_jump    = 1'b1;
                            end
                            default: begin
                                // unknown funct is a no-op
                                rf_we = 1'b0;
                            end
                        endcase
                    end
                    mips_isa_pkg::op_addiu: begin
                        alu_use_imm = 1'b1;
                        rf_we       = 1'b1;
                        pc_advance  = 1'b1;
                    end
                    mips_isa_pkg::op_lw, mips_isa_pkg::op_sw: begin
                        // address only, pc moves after the access
                        alu_use_imm = 1'b1;
                    end
                    mips_isa_pkg::op_beq: begin
                        alu_op     = mips_isa_pkg::alu_sub;
                        pc_branch  = alu_zero;
                        pc_advance = !alu_zero;
                    end
                    default: begin
                        pc_advance = 1'b1;
                    end
                endcase
            end
            st_memory: begin
                // hold the address for the access
                alu_use_imm = 1'b1;
                dram_we     = is_sw;
                pc_advance  = is_sw;
            end
            st_writeback: begin
                alu_use_imm = 1'b1;
                wb_from_mem = 1'b1;
                rf_we       = 1'b1;
                pc_advance  = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_next = st_fetch;
                end
            end
            st_fetch: begin
                state_next = st_execute;
            end
            st_execute: begin
                if (is_lw || is_sw) begin
                    state_next = st_memory;
                end else begin
                    state_next = at_halt ? st_halt : st_fetch;
                end
            end
            st_memory: begin
                if (is_lw) begin
                    state_next = st_writeback;
                end else begin
                    state_next = at_halt ? st_halt : st_fetch;
                end
            end
            st_writeback: begin
                state_next = at_halt ? st_halt : st_fetch;
            end
            default: begin
                // halt holds until reset
                state_next = state;
            end
        endcase
    end

endmodule

// ==== hw/program_counter.sv ====
`timescale 1ns/1ps

module program_counter (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        advance,
    input  logic        branch,
    input  logic        jump,
    input  logic [15:0] branch_offset,
    input  logic [31:0] jump_target,
    output logic [31:0] pc,
    output logic        at_halt
);

    logic [31:0] pc_plus4;
    logic [31:0] branch_disp;
    logic [31:0] next_pc;

    assign pc_plus4 = pc + 32'd4;

    // word offset, sign extended and scaled to bytes
    assign branch_disp = {{14{branch_offset[15]}}, branch_offset, 2'b00};

    always_comb begin
        if (jump) begin
            next_pc = jump_target;
        end else if (branch) begin
            next_pc = pc_plus4 + branch_disp;
        end else if (advance) begin
            next_pc = pc_plus4;
        end else begin
            next_pc = pc;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= mem_map_pkg::start_address;
        end else begin
            pc <= next_pc;
        end
    end

    // only meaningful while an update is being applied
    assign at_halt = (advance || branch || jump) && (next_pc == mem_map_pkg::halt_address);

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [31:0]           a,
    input  logic [31:0]           b,
    input  mips_isa_pkg::alu_op_t op,
    output logic [31:0]           result,
    output logic                  zero
);

    always_comb begin
        case (op)
            mips_isa_pkg::alu_add: begin
                result = a + b;
            end
            mips_isa_pkg::alu_sub: begin
                result = a - b;
            end
            mips_isa_pkg::alu_and: begin
                result = a & b;
            end
            mips_isa_pkg::alu_or: begin
                result = a | b;
            end
            mips_isa_pkg::alu_slt: begin
                // signed compare, so a negative a sets the result
                result = {31'h0, $signed(a) < $signed(b)};
            end
            default: begin
                result = 32'h0;
            end
        endcase
    end

    // beq subtracts and tests this flag
    assign zero = (result == 32'h0);

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [4:0]  rs_index,
    input  logic [4:0]  rt_index,
    input  logic [4:0]  rd_index,
    input  logic [31:0] write_data,
    input  logic        we,
    output logic [31:0] rs_value,
    output logic [31:0] rt_value
);

    // r0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int n = 1; n < 32; n++) begin
                regs[n] <= 32'h0;
            end
        end else if (we && rd_index != 5'd0) begin
            regs[rd_index] <= write_data;
        end
    end

    // both read ports are combinational
    always_comb begin
        rs_value = 32'h0;
        rt_value = 32'h0;
        if (rs_index != 5'd0) begin
            rs_value = regs[rs_index];
        end
        if (rt_index != 5'd0) begin
            rt_value = regs[rt_index];
        end
    end

endmodule

// ==== hw/data_ram.sv ====
`timescale 1ns/1ps

module data_ram (
    input  logic        clk,
    input  logic [31:0] address,
    input  logic [31:0] writedata,
    input  logic        we,
    output logic [31:0] readdata
);

    logic [31:0] mem [0:mem_map_pkg::dram_words-1];

    logic [mem_map_pkg::dram_index_width-1:0] word_index;

    // word aligned accesses only
    assign word_index = address[mem_map_pkg::dram_index_width+1:2];

    // programs expect a cleared data area
    initial begin
        for (int n = 0; n < mem_map_pkg::dram_words; n++) begin
            mem[n] = 32'h0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[word_index] <= writedata;
        end
    end

    // lw sees the stored word in the same cycle
    assign readdata = mem[word_index];

endmodule

// ==== hw/instr_ram.sv ====
`timescale 1ns/1ps

module instr_ram (
    // fetch side, no clock on the read
    input  logic [31:0] instr_address,
    output logic [31:0] instr_readdata,
    // program load side
    input  logic        clk,
    input  logic        prog_we,
    input  logic [31:0] prog_address,
    input  logic [31:0] prog_data
);

    logic [31:0] mem [0:mem_map_pkg::iram_words-1];

    // byte address to word index, low two bits dropped
    logic [mem_map_pkg::iram_index_width-1:0] fetch_index;
    logic [mem_map_pkg::iram_index_width-1:0] load_index;

    assign fetch_index = instr_address[mem_map_pkg::iram_index_width+1:2];
    assign load_index  = prog_address[mem_map_pkg::iram_index_width+1:2];

    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[load_index] <= prog_data;
        end
    end

    assign instr_readdata = mem[fetch_index];

endmodule

// ==== hw/mem_map_pkg.sv ====
package mem_map_pkg;

    // instruction store, 16 KiB
    localparam int iram_words       = 4096;
    localparam int iram_index_width = 12;

    // data store, 4 KiB
    localparam int dram_words       = 1024;
    localparam int dram_index_width = 10;

    // first fetch after reset
    localparam logic [31:0] start_address = 32'h0000_0004;

    // a jump here ends the program
    localparam logic [31:0] halt_address = 32'h0000_0000;

endpackage

// ==== hw/mips_isa_pkg.sv ====
package mips_isa_pkg;

    // primary opcodes, instr[31:26]
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_beq     = 6'b000100;
    localparam logic [5:0] op_addiu   = 6'b001001;
    localparam logic [5:0] op_lw      = 6'b100011;
    localparam logic [5:0] op_sw      = 6'b101011;

    // funct codes under op_special, instr[5:0]
    localparam logic [5:0] fn_jr   = 6'b001000;
    localparam logic [5:0] fn_addu = 6'b100001;
    localparam logic [5:0] fn_subu = 6'b100011;
    localparam logic [5:0] fn_and  = 6'b100100;
    localparam logic [5:0] fn_or   = 6'b100101;
    localparam logic [5:0] fn_slt  = 6'b101010;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_t;

    // immediate format
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // register format
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    // one instruction word, seen through either format
    typedef union packed {
        i_fields_t i;
        r_fields_t r;
    } instr_word_u;

endpackage
